// File: hw/mxu_consts.svh
// ==============================
// build-time sizes for the matrix unit
// deskew and credit logic assume MXU_N of 4 and a power-of-two fifo depth
// ==============================
`ifndef MXU_CONSTS_SVH
`define MXU_CONSTS_SVH

// ==============================
// array geometry and widths
`define MXU_N          4   // array side in rows and columns
`define MXU_DATA_W     8   // signed operand bits
`define MXU_ACC_W      20  // signed column sum bits

// ==============================
// result path
`define MXU_FIFO_DEPTH 8   // result entries and credit limit
`define MXU_PIPE_LAT   8   // accept to push in cycles, twice MXU_N

`endif

// File: hw/mxu_pkg.sv
// ==============================
// shared types for the matrix unit
// lane 0 of every packed vector sits in the low bits
// ==============================
`default_nettype none

`include "mxu_consts.svh"

package mxu_pkg;

    // ==============================
    // operand and sum vectors
    typedef logic signed [`MXU_DATA_W-1:0]      data_t;    // one signed operand
    typedef logic signed [`MXU_ACC_W-1:0]       acc_t;     // one signed column sum
    typedef logic [`MXU_N*`MXU_DATA_W-1:0]      vec_t;     // N operands packed
    typedef logic [`MXU_N*`MXU_ACC_W-1:0]       acc_vec_t; // N sums packed

    // ==============================
    // weight load fsm
    typedef enum logic [1:0] {
        LOAD_EMPTY, // nothing loaded since reset
        LOAD_SHIFT, // rows shifting in
        LOAD_FULL   // all rows valid
    } load_state_t;

endpackage

`default_nettype wire

// File: hw/mac_pe.sv
// ==============================
// one weight-stationary mac cell
// ==============================
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
    input  logic           clk,
    input  logic           reset,
    input  logic           w_shift,   // load weight from the cell below
    input  mxu_pkg::data_t w_in,
    output mxu_pkg::data_t w_out,
    input  mxu_pkg::data_t x_in,
    output mxu_pkg::data_t x_out,
    input  logic           x_vld_in,
    output logic           x_vld_out,
    input  mxu_pkg::acc_t  psum_in,
    output mxu_pkg::acc_t  psum_out
);

    mxu_pkg::data_t weight_q;  // stationary weight
    mxu_pkg::acc_t  product;   // full precision x*w

    assign product = x_in * weight_q;  // sign extended to sum width
    assign w_out   = weight_q;         // feeds the cell above

    always_ff @(posedge clk) begin
        if (w_shift) begin
            weight_q <= w_in;
        end
    end

    // operand moves right and sum moves down in one cycle
    always_ff @(posedge clk) begin
        x_out    <= x_in;
        psum_out <= product + psum_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_vld_out <= 1'b0;
        end else begin
            x_vld_out <= x_vld_in;  // tracks x_out and psum_out
        end
    end

endmodule

`default_nettype wire

// File: hw/systolic_array.sv
// ==============================
// NxN weight-stationary grid with the weight load fsm
// weights shift in at the bottom row and move up one row per beat
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module systolic_array (
    input  logic                clk,
    input  logic                reset,
    input  logic                w_valid,
    output logic                w_ready,
    input  mxu_pkg::vec_t       w_data,       // one weight row per beat
    input  mxu_pkg::vec_t       x_row,        // skewed operands, lane r to row r
    input  logic [`MXU_N-1:0]   x_row_vld,
    input  logic                busy,         // vectors still in flight
    output logic                weights_full,
    output mxu_pkg::acc_vec_t   col_sum,      // bottom row sums
    output logic [`MXU_N-1:0]   col_vld
);

    localparam int CNT_W = $clog2(`MXU_N);

    mxu_pkg::load_state_t state;
    logic [CNT_W-1:0]     beat_cnt;   // beats taken in this load
    logic                 w_shift;

    mxu_pkg::data_t w_feed [`MXU_N+1][`MXU_N];  // row N is the input beat
    mxu_pkg::data_t x_grid [`MXU_N][`MXU_N+1];  // column 0 is the row input
    logic           v_grid [`MXU_N][`MXU_N+1];
    mxu_pkg::acc_t  p_grid [`MXU_N+1][`MXU_N];  // row 0 is the zero seed

    assign w_ready      = !busy;                 // no reload under live data
    assign w_shift      = w_valid && w_ready;
    assign weights_full = (state == mxu_pkg::LOAD_FULL) && !w_valid;  // hold x off a reload

    // ==============================
    // weight load fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= mxu_pkg::LOAD_EMPTY;
            beat_cnt <= '0;
        end else if (w_shift) begin
            case (state)
                mxu_pkg::LOAD_SHIFT: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt == CNT_W'(`MXU_N-1)) begin
                        state <= mxu_pkg::LOAD_FULL;  // last row in place
                    end
                end
                default: begin
                    state    <= mxu_pkg::LOAD_SHIFT;  // first beat of a fresh load
                    beat_cnt <= CNT_W'(1);
                end
            endcase
        end
    end

    // ==============================
    // grid
    for (genvar c = 0; c < `MXU_N; c++) begin : g_edge
        assign w_feed[`MXU_N][c] = w_data[c*`MXU_DATA_W +: `MXU_DATA_W];
        assign p_grid[0][c]      = '0;
        assign col_sum[c*`MXU_ACC_W +: `MXU_ACC_W] = p_grid[`MXU_N][c];
        assign col_vld[c]        = v_grid[`MXU_N-1][c+1];
    end

    for (genvar r = 0; r < `MXU_N; r++) begin : g_row
        assign x_grid[r][0] = x_row[r*`MXU_DATA_W +: `MXU_DATA_W];
        assign v_grid[r][0] = x_row_vld[r];

        for (genvar c = 0; c < `MXU_N; c++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .reset     (reset),
                .w_shift   (w_shift),
                .w_in      (w_feed[r+1][c]),   // from the row below
                .w_out     (w_feed[r][c]),
                .x_in      (x_grid[r][c]),
                .x_out     (x_grid[r][c+1]),
                .x_vld_in  (v_grid[r][c]),
                .x_vld_out (v_grid[r][c+1]),
                .psum_in   (p_grid[r][c]),
                .psum_out  (p_grid[r+1][c])
            );
        end
    end

endmodule

`default_nettype wire

// File: hw/operand_skew.sv
// ==============================
// input acceptor and diagonal skew
// x_ready needs full weights and a free credit in the result fifo
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module operand_skew (
    input  logic               clk,
    input  logic               reset,
    input  logic               x_valid,
    output logic               x_ready,
    input  mxu_pkg::vec_t      x_data,
    input  logic               weights_full,
    input  logic [3:0]         fifo_count,  // current fifo occupancy
    input  logic               push,        // one vector leaves the array
    output mxu_pkg::vec_t      x_row,
    output logic [`MXU_N-1:0]  x_row_vld,
    output logic               busy
);

    logic       accept;
    logic [3:0] in_flight;    // accepted but not yet pushed
    logic [4:0] credit_used;  // in flight plus buffered

    assign credit_used = in_flight + fifo_count;
    assign x_ready     = weights_full && (credit_used < `MXU_FIFO_DEPTH);
    assign accept      = x_valid && x_ready;
    assign busy        = (in_flight != '0);

    // ==============================
    // credit tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            case ({accept, push})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;  // both or neither
            endcase
        end
    end

    // ==============================
    // lane i waits i extra cycles
    for (genvar i = 0; i < `MXU_N; i++) begin : g_lane
        mxu_pkg::data_t lane_q [i+1];  // stage 0 captures at acceptance
        logic [i:0]     vld_q;

        always_ff @(posedge clk) begin
            lane_q[0] <= x_data[i*`MXU_DATA_W +: `MXU_DATA_W];
            for (int s = 1; s <= i; s++) begin
                lane_q[s] <= lane_q[s-1];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= accept;
                for (int s = 1; s <= i; s++) begin
                    vld_q[s] <= vld_q[s-1];
                end
            end
        end

        assign x_row[i*`MXU_DATA_W +: `MXU_DATA_W] = lane_q[i];
        assign x_row_vld[i]                        = vld_q[i];
    end

endmodule

`default_nettype wire

// File: hw/result_deskew.sv
// ==============================
// realigns bottom-row sums into one word
// column j waits N-1-j cycles then one output register
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module result_deskew (
    input  logic               clk,
    input  logic               reset,
    input  mxu_pkg::acc_vec_t  col_sum,
    input  logic [`MXU_N-1:0]  col_vld,
    output logic               push,
    output mxu_pkg::acc_vec_t  push_data
);

    mxu_pkg::acc_t aligned_sum [`MXU_N];  // all columns of one vector together
    logic          aligned_vld [`MXU_N];

    for (genvar j = 0; j < `MXU_N; j++) begin : g_col
        localparam int D = `MXU_N - 1 - j;

        if (D == 0) begin : g_direct
            assign aligned_sum[j] = col_sum[j*`MXU_ACC_W +: `MXU_ACC_W];  // last column
            assign aligned_vld[j] = col_vld[j];
        end else begin : g_delay
            mxu_pkg::acc_t sum_q [D];
            logic [D-1:0]  vld_q;

            always_ff @(posedge clk) begin
                sum_q[0] <= col_sum[j*`MXU_ACC_W +: `MXU_ACC_W];
                for (int s = 1; s < D; s++) begin
                    sum_q[s] <= sum_q[s-1];
                end
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= col_vld[j];
                    for (int s = 1; s < D; s++) begin
                        vld_q[s] <= vld_q[s-1];
                    end
                end
            end

            assign aligned_sum[j] = sum_q[D-1];
            assign aligned_vld[j] = vld_q[D-1];
        end
    end

    // ==============================
    // output word
    always_ff @(posedge clk) begin
        for (int j = 0; j < `MXU_N; j++) begin
            if (aligned_vld[j]) begin
                push_data[j*`MXU_ACC_W +: `MXU_ACC_W] <= aligned_sum[j];  // lane holds otherwise
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= aligned_vld[0];  // column 0 marks the vector
        end
    end

endmodule

`default_nettype wire

// File: hw/result_fifo.sv
// ==============================
// result buffer with show-ahead read
// push side has no full check and relies on skewer credits
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module result_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  mxu_pkg::acc_vec_t  push_data,
    output logic               pop_valid,
    input  logic               pop_ready,
    output mxu_pkg::acc_vec_t  pop_data,
    output logic [3:0]         count      // occupancy for credit return
);

    localparam int PTR_W = $clog2(`MXU_FIFO_DEPTH);

    mxu_pkg::acc_vec_t mem [`MXU_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              pop;

    assign pop_valid = (count != '0);
    assign pop       = pop_valid && pop_ready;
    assign pop_data  = mem[rd_ptr];  // head word visible without a read cycle

    // ==============================
    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ==============================
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/activation_out.sv
// ==============================
// relu and output register
// relu_en is sampled as words enter the register
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module activation_out (
    input  logic               clk,
    input  logic               reset,
    input  logic               relu_en,
    input  logic               in_valid,
    output logic               in_ready,
    input  mxu_pkg::acc_vec_t  in_data,
    output logic               y_valid,
    input  logic               y_ready,
    output mxu_pkg::acc_vec_t  y_data
);

    mxu_pkg::acc_vec_t act_data;  // clamped word before the register

    assign in_ready = !y_valid || y_ready;  // empty or draining this cycle

    always_comb begin
        mxu_pkg::acc_t lane;
        act_data = in_data;
        for (int j = 0; j < `MXU_N; j++) begin
            lane = in_data[j*`MXU_ACC_W +: `MXU_ACC_W];
            if (relu_en && lane[`MXU_ACC_W-1]) begin
                act_data[j*`MXU_ACC_W +: `MXU_ACC_W] = '0;  // negative lane to zero
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            y_data <= act_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            y_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            y_valid <= 1'b1;  // refill in the same cycle as the take
        end else if (y_ready) begin
            y_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/matrix_unit_top.sv
// ==============================
// weight-stationary matrix unit top
// relu_en must stay stable while results are pending
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module matrix_unit_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               w_valid,
    output logic               w_ready,
    input  mxu_pkg::vec_t      w_data,
    input  logic               x_valid,
    output logic               x_ready,
    input  mxu_pkg::vec_t      x_data,
    output logic               y_valid,
    input  logic               y_ready,
    output mxu_pkg::acc_vec_t  y_data,
    input  logic               relu_en
);

    // ==============================
    // internal links
    mxu_pkg::vec_t      x_row;
    logic [`MXU_N-1:0]  x_row_vld;
    logic               busy;          // skewer to array
    logic               weights_full;  // array to skewer
    mxu_pkg::acc_vec_t  col_sum;
    logic [`MXU_N-1:0]  col_vld;
    logic               push;
    mxu_pkg::acc_vec_t  push_data;
    logic [3:0]         fifo_count;
    logic               fifo_valid;
    logic               fifo_ready;
    mxu_pkg::acc_vec_t  fifo_data;

    // ==============================
    // producer
    operand_skew u_skew (
        .clk          (clk),
        .reset        (reset),
        .x_valid      (x_valid),
        .x_ready      (x_ready),
        .x_data       (x_data),
        .weights_full (weights_full),
        .fifo_count   (fifo_count),
        .push         (push),        // credit return
        .x_row        (x_row),
        .x_row_vld    (x_row_vld),
        .busy         (busy)
    );

    systolic_array u_array (
        .clk          (clk),
        .reset        (reset),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w_data       (w_data),
        .x_row        (x_row),
        .x_row_vld    (x_row_vld),
        .busy         (busy),
        .weights_full (weights_full),
        .col_sum      (col_sum),
        .col_vld      (col_vld)
    );

    result_deskew u_deskew (
        .clk       (clk),
        .reset     (reset),
        .col_sum   (col_sum),
        .col_vld   (col_vld),
        .push      (push),
        .push_data (push_data)
    );

    // ==============================
    // buffer and consumer
    result_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop_valid (fifo_valid),
        .pop_ready (fifo_ready),
        .pop_data  (fifo_data),
        .count     (fifo_count)
    );

    activation_out u_act (
        .clk      (clk),
        .reset    (reset),
        .relu_en  (relu_en),
        .in_valid (fifo_valid),
        .in_ready (fifo_ready),
        .in_data  (fifo_data),
        .y_valid  (y_valid),
        .y_ready  (y_ready),
        .y_data   (y_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_matrix_unit.sv
// ==============================
// self-checking testbench with a queue model of the matrix rule
// relu_en only changes while no result is pending
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "mxu_consts.svh"

module tb_matrix_unit;

    localparam int HALF_PERIOD = 50;    // 100 ns clock
    localparam int HS_TIMEOUT  = 200;   // cycles per handshake wait
    localparam int DRAIN_LIMIT = 3000;  // cycles to empty the pipeline

    logic               clk;
    logic               reset;
    logic               w_valid;
    logic               w_ready;
    mxu_pkg::vec_t      w_data;
    logic               x_valid;
    logic               x_ready;
    mxu_pkg::vec_t      x_data;
    logic               y_valid;
    logic               y_ready;
    mxu_pkg::acc_vec_t  y_data;
    logic               relu_en;

    // ==============================
    // model state
    mxu_pkg::data_t     w_model [`MXU_N][`MXU_N];  // row k holds weight beat k
    mxu_pkg::acc_vec_t  exp_q [$];                 // accepted but not yet read
    mxu_pkg::acc_vec_t  exp_now;                   // expected word at this y take
    logic               exp_avail;
    int                 pending_pre;               // queue size before this edge
    int                 w_beats;                   // beats in the current load
    logic [`MXU_PIPE_LAT-1:0] accept_hist;         // recent x acceptances
    logic               busy_exp;
    logic [15:0]        stim_lfsr;
    logic [15:0]        ready_lfsr;
    logic               stall_mode;
    logic               aborted;
    int                 value_errors;
    int                 protocol_errors;
    int                 timeouts;
    int                 checked;

    matrix_unit_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .w_data  (w_data),
        .x_valid (x_valid),
        .x_ready (x_ready),
        .x_data  (x_data),
        .y_valid (y_valid),
        .y_ready (y_ready),
        .y_data  (y_data),
        .relu_en (relu_en)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ==============================
    // random source and reference
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);  // one step per bit
            r = {r[30:0], s[0]};
        end
        return r;
    endfunction

    function automatic mxu_pkg::acc_vec_t matrix_rule(input mxu_pkg::vec_t xv,
                                                      input logic relu);
        mxu_pkg::acc_vec_t res;
        int sum;
        int xk;
        res = '0;
        for (int j = 0; j < `MXU_N; j++) begin
            sum = 0;
            for (int k = 0; k < `MXU_N; k++) begin
                xk = $signed(xv[k*`MXU_DATA_W +: `MXU_DATA_W]);
                sum += xk * int'(w_model[k][j]);  // x lane k times row k col j
            end
            if (relu && sum < 0) begin
                sum = 0;
            end
            res[j*`MXU_ACC_W +: `MXU_ACC_W] = sum[`MXU_ACC_W-1:0];
        end
        return res;
    endfunction

    // ==============================
    // scoreboard, sampled one ns before each rising edge
    initial begin : scoreboard
        logic x_fire;
        logic y_fire;
        logic w_fire;
        exp_avail   = 1'b0;
        exp_now     = '0;
        pending_pre = 0;
        w_beats     = 0;
        accept_hist = '0;
        busy_exp    = 1'b0;
        checked     = 0;
        forever begin
            @(negedge clk);
            #(HALF_PERIOD - 1);  // inputs and ready lines settled
            x_fire      = !reset && x_valid && x_ready;
            y_fire      = !reset && y_valid && y_ready;
            w_fire      = !reset && w_valid && w_ready;
            pending_pre = exp_q.size();
            exp_avail   = (pending_pre != 0);
            busy_exp    = (accept_hist != '0);  // accepted within the last 8 edges
            accept_hist = {accept_hist[`MXU_PIPE_LAT-2:0], x_fire};
            if (y_fire && exp_avail) begin
                exp_now = exp_q.pop_front();
                checked++;
            end
            if (w_fire) begin
                for (int r = 0; r < `MXU_N - 1; r++) begin
                    for (int c = 0; c < `MXU_N; c++) begin
                        w_model[r][c] = w_model[r+1][c];  // earlier rows move up
                    end
                end
                for (int c = 0; c < `MXU_N; c++) begin
                    w_model[`MXU_N-1][c] = w_data[c*`MXU_DATA_W +: `MXU_DATA_W];
                end
                w_beats = (w_beats == `MXU_N) ? 1 : w_beats + 1;  // fifth beat restarts
            end
            if (x_fire) begin
                exp_q.push_back(matrix_rule(x_data, relu_en));
            end
        end
    end

    // ==============================
    // checks
    a_x_held: assert property (@(posedge clk) disable iff (reset)
        (w_beats != `MXU_N) |-> !x_ready)
        else begin
            value_errors++;
            $display("FAIL x_ready expected 0 got %h", $sampled(x_ready));
        end

    a_w_busy: assert property (@(posedge clk) disable iff (reset)
        busy_exp |-> !w_ready)
        else begin
            value_errors++;
            $display("FAIL w_ready expected 0 got %h", $sampled(w_ready));
        end

    a_y_expected: assert property (@(posedge clk) disable iff (reset)
        y_valid |-> exp_avail)
        else begin
            protocol_errors++;
            $display("y_valid is high although no accepted vector is pending");
        end

    a_y_data: assert property (@(posedge clk) disable iff (reset)
        (y_valid && y_ready && exp_avail) |-> (y_data == exp_now))
        else begin
            value_errors++;
            $display("FAIL y_data expected %h got %h", exp_now, $sampled(y_data));
        end

    a_credit: assert property (@(posedge clk) disable iff (reset)
        pending_pre <= `MXU_FIFO_DEPTH + 1)
        else begin
            protocol_errors++;
            $display("more vectors accepted than the result path can hold");
        end

    a_credit_stop: assert property (@(posedge clk) disable iff (reset)
        (pending_pre > `MXU_FIFO_DEPTH) |-> !x_ready)
        else begin
            value_errors++;
            $display("FAIL x_ready expected 0 got %h", $sampled(x_ready));
        end

    // ==============================
    // stimulus
    initial begin : ready_driver
        int run;
        logic [31:0] bits;
        y_ready = 1'b1;
        run = 0;
        forever begin
            @(negedge clk);
            if (!stall_mode) begin
                y_ready = 1'b1;
                run = 0;
            end else begin
                if (run == 0) begin
                    bits = take_bits(ready_lfsr, 5);
                    y_ready = bits[4];
                    run = 1 + int'(bits[3:0]);
                    if (!y_ready) begin
                        run = run + 8;  // long stalls fill the fifo
                    end
                end
                run--;
            end
        end
    end

    task automatic flag_timeout(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("timed out while waiting for %s", what);
    endtask

    task automatic send_x_vector(input mxu_pkg::vec_t v);
        int waited;
        logic taken;
        if (aborted) return;
        waited  = 0;
        taken   = 1'b0;
        x_valid = 1'b1;
        x_data  = v;
        while (!taken && waited < HS_TIMEOUT) begin
            #1;                // x_ready settles after the drive
            taken = x_ready;
            @(negedge clk);
            waited++;
        end
        x_valid = 1'b0;
        if (!taken) flag_timeout("x_ready");
    endtask

    task automatic send_weight_row(input mxu_pkg::vec_t v);
        int waited;
        logic taken;
        if (aborted) return;
        waited  = 0;
        taken   = 1'b0;
        w_valid = 1'b1;
        w_data  = v;
        while (!taken && waited < HS_TIMEOUT) begin
            #1;
            taken = w_ready;
            @(negedge clk);
            waited++;
        end
        w_valid = 1'b0;
        if (!taken) flag_timeout("w_ready");
    endtask

    task automatic load_weights();
        int gap;
        for (int r = 0; r < `MXU_N; r++) begin
            gap = take_bits(stim_lfsr, 1);
            repeat (gap) @(negedge clk);
            send_weight_row(take_bits(stim_lfsr, 32));
        end
    endtask

    task automatic send_burst(input int n, input logic gaps);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = gaps ? int'(take_bits(stim_lfsr, 2)) : 0;  // 0 means back to back
            repeat (gap) @(negedge clk);
            send_x_vector(take_bits(stim_lfsr, 32));
        end
    endtask

    task automatic wait_drained();
        int waited;
        if (aborted) return;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) flag_timeout("all results to be read");
    endtask

    initial begin : main_sequence
        reset           = 1'b1;
        w_valid         = 1'b0;
        w_data          = '0;
        x_valid         = 1'b0;
        x_data          = '0;
        relu_en         = 1'b0;
        stall_mode      = 1'b0;
        aborted         = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        stim_lfsr       = 16'd54;
        ready_lfsr      = 16'd54;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        repeat (6) @(negedge clk);  // weights empty, x_ready held low
        load_weights();
        send_burst(24, 1'b1);       // plain matrix rule
        send_burst(16, 1'b0);
        wait_drained();
        relu_en = 1'b1;
        send_burst(24, 1'b1);
        send_burst(8, 1'b0);
        wait_drained();
        relu_en    = 1'b0;
        stall_mode = 1'b1;          // back-pressure from the consumer
        send_burst(60, 1'b0);
        wait_drained();
        send_burst(8, 1'b0);
        load_weights();             // reload behind vectors still in flight
        send_burst(20, 1'b1);
        wait_drained();
        stall_mode = 1'b0;
        relu_en    = 1'b1;
        send_burst(12, 1'b0);
        wait_drained();
        $display("value errors %0d, protocol errors %0d, timeouts %0d, results checked %0d",
                 value_errors, protocol_errors, timeouts, checked);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0 && checked > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/mxu_pkg.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/operand_skew.sv
hw/result_deskew.sv
hw/result_fifo.sv
hw/activation_out.sv
hw/matrix_unit_top.sv
testbench/tb_matrix_unit.sv
